//--- verif/ti_glue_trace.txt
# op f1 f2 f3 f4 f5, all hex. C: {iaq,int_req,wr} addr {xram,vdp_rd,vdp_wr,ready} ack_dly xaddr
# W: ofs wdata hold_reset  R: ofs rdata  K: line_sel keyline  T: entry wptr
C 0 1000 9 2 000800
C 1 1000 0 1 000800
C 1 2004 9 3 001002
C 0 8800 5 2 004400
C 1 8c00 3 1 004600
C 1 600a 0 0 025005
C 0 7ffe 9 2 025fff
C 1 6006 0 0 023003
C 0 6100 9 1 023080
C 6 a002 9 2 005001
C 1 fffe 9 1 007fff
C 1 4000 0 2 002000
W 007 7f 0 0 0
K 7 7f 0 0 0
R 007 7f 0 0 0
R 005 ff 0 0 0
W 008 fe 1 0 0
R 008 fe 0 0 0
W 009 ff 0 0 0
W 00c 55 0 0 0
R 00c 00 0 0 0
T 000 0c 0 0 0
T 006 0c 0 0 0
T 009 0c 0 0 0

//--- filelist.f
logic/ti_glue_pkg.sv
logic/cpu_bus_decode.sv
logic/cart_bank_mapper.sv
logic/trace_buffer.sv
logic/loader_regs.sv
logic/ti_glue_top.sv
verif/tb_ti_glue.sv

//--- run.sh
#!/bin/sh
# Build and run the TI-99/4A glue testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --top-module tb_ti_glue -f filelist.f -o sim_ti_glue
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_ti_glue > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qF '*** TEST PASSED ***' sim.log; then
  exit 0
fi
exit 1

//--- verif/tb_ti_glue.sv
/*
 * Testbench for the TI-99/4A system glue.
 * Replays verif/ti_glue_trace.txt step by step (CPU accesses, loader accesses,
 * key selects, trace readback) and checks the DUT against the file's expected values.
 */
`timescale 1ns/10ps

module tb_ti_glue;

  import ti_glue_pkg::*;

  localparam int    CLK_PERIOD = 8;
  localparam int    ACK_LIMIT  = 8;  // Loader ack search window
  localparam string TRACE_FILE = "verif/ti_glue_trace.txt";

  logic clk, cpu_reset;
  cpu_addr_t cpu_addr_i;
  logic cpu_rd_i, cpu_wr_i, iaq_i, int_req_i, mem_ack_i, vdp_ack_i;
  logic [CPU_DW-1:0] cpu_dout_i, cpu_din_i;
  logic ready_o, xram_sel_o, vdp_rd_o, vdp_wr_o, mem_rd_rq_o, mem_wr_rq_o;
  xaddr_t xaddr_o;
  logic loader_wr_i, loader_rd_i, loader_ack_o, cpu_hold_reset_o;
  loader_ofs_u loader_ofs_i;
  logic [7:0] loader_wdata_i, loader_rdata_o, keyline_o;
  logic [2:0] line_sel_i;

  byte          op_q[$];   // Step opcodes
  logic [31:0]  fld_q[$];  // Five fields per step
  trace_entry_t rec_q[$];  // Expected trace, one per CPU access
  int checks, mismatches, other_errs;
  bit loaded;

  ti_glue_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Limit scales with the number of trace steps
  initial begin
    wait (loaded);
    #((op_q.size() * 20 + 100) * CLK_PERIOD);
    $display("Watchdog expired, the DUT stopped making progress");
    $display("*** TEST FAILED ***");
    $finish;
  end

  //----------------------------------------
  // Compare tasks
  //----------------------------------------
  task automatic check_sel(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
      mismatches++;
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
      mismatches++;
    end
  endtask

  task automatic check_xaddr(input xaddr_t got, input xaddr_t exp);
    checks++;
    if (got !== exp) begin
      $display("Mismatch xaddr_o: got %h expected %h at %0t", got, exp, $time);
      mismatches++;
    end
  endtask

  task automatic check_entry(input int idx, input trace_entry_t got, input trace_entry_t exp);
    checks++;
    if (got !== exp) begin
      $display("Mismatch trace entry %0d: got %h expected %h", idx, got, exp);
      mismatches++;
    end
  endtask

  //----------------------------------------
  // Bus drivers
  //----------------------------------------
  // ctl = {iaq, int_req, wr}; flags = {xram_sel, vdp_rd, vdp_wr, ready}
  task automatic cpu_access(input logic [2:0] ctl, input cpu_addr_t addr,
                            input logic [3:0] flags, input int ack_dly, input xaddr_t exp_xaddr);
    logic wr, vdp;
    logic [15:0] dout, din;
    int len;
    trace_entry_t ent;
    wr   = ctl[0];
    vdp  = flags[2] || flags[1];           // VDP cycles get vdp_ack
    len  = (ack_dly > 0) ? ack_dly + 2 : 2;  // Two cycles past the ack
    dout = 16'($urandom);
    din  = 16'($urandom);
    @(posedge clk);
    cpu_addr_i <= addr;
    cpu_rd_i   <= !wr;
    cpu_wr_i   <= wr;
    cpu_dout_i <= dout;
    cpu_din_i  <= din;
    iaq_i      <= ctl[2];
    int_req_i  <= ctl[1];
    for (int cyc = 1; cyc <= len; cyc++) begin
      if (cyc > 1)
        @(posedge clk);
      mem_ack_i <= (cyc == ack_dly) && !vdp;  // One-cycle ack
      vdp_ack_i <= (cyc == ack_dly) && vdp;
      @(negedge clk);
      check_sel("xram_sel_o", xram_sel_o, flags[3]);
      check_sel("vdp_rd_o", vdp_rd_o, flags[2]);
      check_sel("vdp_wr_o", vdp_wr_o, flags[1] && cyc == 1);
      check_sel("mem_rd_rq_o", mem_rd_rq_o, flags[3] && !wr && cyc == 1);
      check_sel("mem_wr_rq_o", mem_wr_rq_o, flags[3] && wr && cyc == 1);
      check_sel("ready_o", ready_o, flags[0] && ack_dly > 0 && cyc >= ack_dly);
    end
    check_xaddr(xaddr_o, exp_xaddr);  // Bank page has settled by now
    @(posedge clk);
    cpu_rd_i  <= 1'b0;
    cpu_wr_i  <= 1'b0;
    mem_ack_i <= 1'b0;
    vdp_ack_i <= 1'b0;
    @(posedge clk);  // Hold register clears on this edge
    @(negedge clk);
    check_sel("ready_o", ready_o, 1'b0);
    ent.ctrl = {ctl[2], ctl[1], wr, !wr};
    ent.data = wr ? dout : din;
    ent.addr = addr;
    rec_q.push_back(ent);
  endtask

  task automatic wait_ack;
    int lat;
    lat = 1;
    @(negedge clk);
    while (!loader_ack_o && lat < ACK_LIMIT) begin
      @(negedge clk);
      lat++;
    end
    if (!loader_ack_o) begin
      $display("Loader ack never came within %0d cycles", ACK_LIMIT);
      other_errs++;
    end else if (lat != 1) begin
      $display("Mismatch loader_ack_o latency: got %h expected %h", lat, 1);
      mismatches++;
    end
  endtask

  task automatic loader_write(input loader_ofs_u ofs, input logic [7:0] data, input logic hold);
    @(posedge clk);
    loader_wr_i    <= 1'b1;
    loader_ofs_i   <= ofs;
    loader_wdata_i <= data;
    @(posedge clk);
    loader_wr_i <= 1'b0;
    wait_ack();
    check_sel("cpu_hold_reset_o", cpu_hold_reset_o, hold);
  endtask

  task automatic loader_read(input loader_ofs_u ofs, output logic [7:0] data);
    @(posedge clk);
    loader_rd_i  <= 1'b1;
    loader_ofs_i <= ofs;
    @(posedge clk);
    loader_rd_i <= 1'b0;
    wait_ack();
    data = loader_rdata_o;  // Valid in the ack cycle
  endtask

  task automatic key_select(input logic [2:0] sel, input logic [7:0] exp);
    @(posedge clk);
    line_sel_i <= sel;
    @(posedge clk);
    @(negedge clk);
    check_byte("keyline_o", keyline_o, exp);
  endtask

  task automatic trace_check(input logic [7:0] k, input logic [7:0] exp_wptr);
    loader_ofs_u ofs;
    logic [7:0] b [8];
    trace_entry_t got;
    ofs = '0;
    ofs.trace_view.is_trace = 1'b1;
    ofs.trace_view.entry    = k;
    for (int s = 2; s < 8; s++) begin
      ofs.trace_view.byte_sel = 3'(s);
      loader_read(ofs, b[s]);
    end
    check_byte("trace wptr", b[2], exp_wptr);
    got.ctrl = b[3][3:0];
    got.data = {b[4], b[5]};
    got.addr = {b[6], b[7]};
    if (k >= rec_q.size()) begin
      $display("Trace entry %0d requested but only %0d CPU accesses ran", k, rec_q.size());
      other_errs++;
    end else
      check_entry(k, got, rec_q[k]);
  endtask

  //----------------------------------------
  // Trace file
  //----------------------------------------
  task automatic load_trace;
    int fd, n;
    string line, op;
    logic [31:0] f1, f2, f3, f4, f5;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the trace file %s", TRACE_FILE);
      other_errs++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line[0] == "#")
        continue;  // Blank or comment
      n = $sscanf(line, "%s %h %h %h %h %h", op, f1, f2, f3, f4, f5);
      if (n != 6) begin
        $display("Badly formed trace line: %s", line);
        other_errs++;
        continue;
      end
      op_q.push_back(op[0]);
      fld_q.push_back(f1);
      fld_q.push_back(f2);
      fld_q.push_back(f3);
      fld_q.push_back(f4);
      fld_q.push_back(f5);
    end
    $fclose(fd);
  endtask

  task automatic run_step(input byte op, input logic [31:0] f1, f2, f3, f4, f5);
    logic [7:0] got;
    case (op)
      "C": cpu_access(f1[2:0], f2[15:0], f3[3:0], int'(f4), f5[22:0]);
      "W": loader_write(f1[11:0], f2[7:0], f3[0]);
      "R": begin
        loader_read(f1[11:0], got);
        check_byte("loader_rdata_o", got, f2[7:0]);
      end
      "K": key_select(f1[2:0], f2[7:0]);
      "T": trace_check(f1[7:0], f2[7:0]);
      default: begin
        $display("Unknown trace step opcode %c", op);
        other_errs++;
      end
    endcase
  endtask

  initial begin
    void'($urandom(88641));
    cpu_reset      = 1'b1;
    cpu_addr_i     = '0;
    cpu_rd_i       = 1'b0;
    cpu_wr_i       = 1'b0;
    cpu_dout_i     = '0;
    cpu_din_i      = '0;
    iaq_i          = 1'b0;
    int_req_i      = 1'b0;
    mem_ack_i      = 1'b0;
    vdp_ack_i      = 1'b0;
    loader_wr_i    = 1'b0;
    loader_rd_i    = 1'b0;
    loader_ofs_i   = '0;
    loader_wdata_i = 8'h00;
    line_sel_i     = 3'd0;
    load_trace();
    loaded = 1'b1;
    repeat (8) @(posedge clk);
    cpu_reset <= 1'b0;
    @(negedge clk);
    check_sel("ready_o", ready_o, 1'b0);  // Reset state
    check_sel("cpu_hold_reset_o", cpu_hold_reset_o, 1'b0);
    check_byte("keyline_o", keyline_o, 8'hff);
    for (int i = 0; i < op_q.size(); i++)
      run_step(op_q[i], fld_q[5*i], fld_q[5*i+1], fld_q[5*i+2], fld_q[5*i+3], fld_q[5*i+4]);
    $display("Checks: %0d, mismatches: %0d, other errors: %0d", checks, mismatches, other_errs);
    if (mismatches == 0 && other_errs == 0 && op_q.size() > 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- logic/ti_glue_top.sv
/*
 * TI-99/4A system glue top level.
 * Connects the bus decode, cartridge mapper, trace buffer and loader registers.
 */
`timescale 1ns/10ps

module ti_glue_top (
  input  logic                                     clk,
  input  logic                                     cpu_reset,
  // CPU bus
  input  ti_glue_pkg::cpu_addr_t                   cpu_addr_i,
  input  logic                                     cpu_rd_i,
  input  logic                                     cpu_wr_i,
  input  logic [ti_glue_pkg::CPU_DW-1:0]           cpu_dout_i,
  input  logic [ti_glue_pkg::CPU_DW-1:0]           cpu_din_i,
  input  logic                                     iaq_i,
  input  logic                                     int_req_i,
  output logic                                     ready_o,
  // External memory and VDP
  input  logic                                     mem_ack_i,
  input  logic                                     vdp_ack_i,
  output logic                                     xram_sel_o,
  output logic                                     vdp_rd_o,
  output logic                                     vdp_wr_o,
  output logic                                     mem_rd_rq_o,
  output logic                                     mem_wr_rq_o,
  output ti_glue_pkg::xaddr_t                      xaddr_o,
  // Loader port
  input  logic                                     loader_wr_i,
  input  logic                                     loader_rd_i,
  input  ti_glue_pkg::loader_ofs_u                 loader_ofs_i,
  input  logic [7:0]                               loader_wdata_i,
  output logic [7:0]                               loader_rdata_o,
  output logic                                     loader_ack_o,
  // Keyboard and reset control
  input  logic [$clog2(ti_glue_pkg::KEY_ROWS)-1:0] line_sel_i,
  output logic [7:0]                               keyline_o,
  output logic                                     cpu_hold_reset_o
);

  import ti_glue_pkg::*;

  logic                cart_sel, cart_wr_rq;
  trace_entry_t        trace_rd_entry;
  logic [TRACE_AW-1:0] trace_rd_idx, trace_wptr;

  cpu_bus_decode i_bus_decode (
    .clk(clk), .cpu_reset(cpu_reset),
    .cpu_addr_i(cpu_addr_i), .cpu_rd_i(cpu_rd_i), .cpu_wr_i(cpu_wr_i),
    .mem_ack_i(mem_ack_i), .vdp_ack_i(vdp_ack_i),
    .xram_sel_o(xram_sel_o), .cart_sel_o(cart_sel),
    .vdp_rd_o(vdp_rd_o), .vdp_wr_o(vdp_wr_o),
    .mem_rd_rq_o(mem_rd_rq_o), .mem_wr_rq_o(mem_wr_rq_o),
    .cart_wr_rq_o(cart_wr_rq), .ready_o(ready_o)
  );

  cart_bank_mapper i_cart_map (
    .clk(clk), .cpu_reset(cpu_reset),
    .cpu_addr_i(cpu_addr_i), .cart_sel_i(cart_sel), .cart_wr_rq_i(cart_wr_rq),
    .xaddr_o(xaddr_o)
  );

  trace_buffer i_trace (
    .clk(clk), .cpu_reset(cpu_reset),
    .cpu_addr_i(cpu_addr_i), .cpu_rd_i(cpu_rd_i), .cpu_wr_i(cpu_wr_i),
    .cpu_dout_i(cpu_dout_i), .cpu_din_i(cpu_din_i),
    .iaq_i(iaq_i), .int_req_i(int_req_i),
    .rd_entry_i(trace_rd_idx), .rd_data_o(trace_rd_entry), .wptr_o(trace_wptr)
  );

  loader_regs i_loader (
    .clk(clk), .cpu_reset(cpu_reset),
    .loader_wr_i(loader_wr_i), .loader_rd_i(loader_rd_i),
    .loader_ofs_i(loader_ofs_i), .loader_wdata_i(loader_wdata_i),
    .line_sel_i(line_sel_i),
    .trace_rd_entry_i(trace_rd_entry), .trace_wptr_i(trace_wptr),
    .loader_rdata_o(loader_rdata_o), .loader_ack_o(loader_ack_o),
    .keyline_o(keyline_o), .cpu_hold_reset_o(cpu_hold_reset_o),
    .trace_rd_idx_o(trace_rd_idx)
  );

endmodule

//--- logic/loader_regs.sv
/*
 * Loader register port: keyboard rows, CPU reset control and trace readback.
 * Single-cycle rd/wr strobes, acknowledged one cycle later with read data.
 */
`timescale 1ns/10ps

module loader_regs (
  input  logic                                        clk,
  input  logic                                        cpu_reset,
  input  logic                                        loader_wr_i,
  input  logic                                        loader_rd_i,
  input  ti_glue_pkg::loader_ofs_u                    loader_ofs_i,
  input  logic [7:0]                                  loader_wdata_i,
  input  logic [$clog2(ti_glue_pkg::KEY_ROWS)-1:0]    line_sel_i,
  input  ti_glue_pkg::trace_entry_t                   trace_rd_entry_i,
  input  logic [ti_glue_pkg::TRACE_AW-1:0]            trace_wptr_i,
  output logic [7:0]                                  loader_rdata_o,
  output logic                                        loader_ack_o,
  output logic [7:0]                                  keyline_o,
  output logic                                        cpu_hold_reset_o,
  output logic [ti_glue_pkg::TRACE_AW-1:0]            trace_rd_idx_o
);

  import ti_glue_pkg::*;

  logic [7:0] key_rows [KEY_ROWS];  // Low bit = key down
  logic [7:0] ctrl_reg;             // Bit 0 low holds the CPU in reset
  logic [7:0] rd_byte;
  logic       reg_hit, key_hit, ctrl_hit;

  //----------------------------------------
  // Offset decode
  //----------------------------------------
  assign reg_hit  = !loader_ofs_i.reg_view.is_trace && (loader_ofs_i.reg_view.pad_zero == '0);
  assign key_hit  = reg_hit && !loader_ofs_i.reg_view.reg_idx[3];          // 0-7
  assign ctrl_hit = reg_hit && (loader_ofs_i.reg_view.reg_idx[3:1] == 3'b100);  // 8-9

  assign trace_rd_idx_o = loader_ofs_i.trace_view.entry;  // Buffer answers combinationally

  always_comb begin
    rd_byte = 8'h00;
    if (loader_ofs_i.trace_view.is_trace) begin
      case (loader_ofs_i.trace_view.byte_sel)
        3'd2:    rd_byte = trace_wptr_i;
        3'd3:    rd_byte = {4'h0, trace_rd_entry_i.ctrl};
        3'd4:    rd_byte = trace_rd_entry_i.data[15:8];
        3'd5:    rd_byte = trace_rd_entry_i.data[7:0];
        3'd6:    rd_byte = trace_rd_entry_i.addr[15:8];
        3'd7:    rd_byte = trace_rd_entry_i.addr[7:0];
        default: rd_byte = 8'h00;  // Bytes 0-1 unused
      endcase
    end else if (key_hit) begin
      rd_byte = key_rows[loader_ofs_i.reg_view.reg_idx[2:0]];
    end else if (ctrl_hit) begin
      rd_byte = ctrl_reg;
    end
  end

  //----------------------------------------
  // Register writes and ack
  //----------------------------------------
  always_ff @(posedge clk) begin
    if (cpu_reset) begin
      for (int i = 0; i < KEY_ROWS; i++)
        key_rows[i] <= 8'hff;  // All keys up
      ctrl_reg     <= 8'hff;
      loader_ack_o <= 1'b0;
    end else begin
      loader_ack_o <= loader_wr_i || loader_rd_i;  // Unknown offsets still acked
      if (loader_wr_i && key_hit)
        key_rows[loader_ofs_i.reg_view.reg_idx[2:0]] <= loader_wdata_i;
      if (loader_wr_i && ctrl_hit)
        ctrl_reg <= loader_wdata_i;
    end
  end

  // Read data holds until the next read
  always_ff @(posedge clk) begin
    if (loader_rd_i)
      loader_rdata_o <= rd_byte;
    keyline_o <= key_rows[line_sel_i];  // Row scan from the 9901 side
  end

  assign cpu_hold_reset_o = !ctrl_reg[0];

  a_loader_excl: assert property (@(posedge clk) disable iff (cpu_reset)
    !(loader_rd_i && loader_wr_i))
    else $error("loader read and write strobes together");

endmodule

//--- logic/trace_buffer.sv
/*
 * 256-entry CPU bus trace buffer.
 * Each active bus cycle overwrites the entry at the pointer; the pointer
 * moves on once the cycle ends. Entries are read back asynchronously.
 */
`timescale 1ns/10ps

module trace_buffer (
  input  logic                                 clk,
  input  logic                                 cpu_reset,
  input  ti_glue_pkg::cpu_addr_t               cpu_addr_i,
  input  logic                                 cpu_rd_i,
  input  logic                                 cpu_wr_i,
  input  logic [ti_glue_pkg::CPU_DW-1:0]       cpu_dout_i,
  input  logic [ti_glue_pkg::CPU_DW-1:0]       cpu_din_i,
  input  logic                                 iaq_i,
  input  logic                                 int_req_i,
  input  logic [ti_glue_pkg::TRACE_AW-1:0]     rd_entry_i,
  output ti_glue_pkg::trace_entry_t            rd_data_o,
  output logic [ti_glue_pkg::TRACE_AW-1:0]     wptr_o
);

  import ti_glue_pkg::*;

  trace_entry_t        trace_mem [2**TRACE_AW];
  trace_entry_t        wr_entry;
  logic [TRACE_AW-1:0] wptr;
  logic                trace_we, last_we;

  assign trace_we      = cpu_rd_i || cpu_wr_i;
  assign wr_entry.ctrl = {iaq_i, int_req_i, cpu_wr_i, cpu_rd_i};
  assign wr_entry.data = cpu_wr_i ? cpu_dout_i : cpu_din_i;  // Data as seen by the CPU
  assign wr_entry.addr = cpu_addr_i;

  always_ff @(posedge clk) begin
    if (trace_we)
      trace_mem[wptr] <= wr_entry;  // Last cycle of the access wins
  end

  always_ff @(posedge clk) begin
    if (cpu_reset) begin
      wptr    <= '0;
      last_we <= 1'b0;
    end else begin
      last_we <= trace_we;
      if (last_we && !trace_we)
        wptr <= wptr + 1'b1;  // Access finished
    end
  end

  assign rd_data_o = trace_mem[rd_entry_i];
  assign wptr_o    = wptr;

  // One access keeps its address, so each slot holds a single bus cycle
  a_addr_hold: assert property (@(posedge clk) disable iff (cpu_reset)
    trace_we && last_we |-> $stable(cpu_addr_i))
    else $error("CPU address changed during a bus cycle");

endmodule

//--- logic/cart_bank_mapper.sv
/*
 * Extended Basic cartridge bank register and CPU to external address mapping.
 * A write anywhere in 6000-7FFF latches the page from address bits 5..1.
 */
`timescale 1ns/10ps

module cart_bank_mapper (
  input  logic                   clk,
  input  logic                   cpu_reset,
  input  ti_glue_pkg::cpu_addr_t cpu_addr_i,
  input  logic                   cart_sel_i,
  input  logic                   cart_wr_rq_i,
  output ti_glue_pkg::xaddr_t    xaddr_o
);

  import ti_glue_pkg::*;

  // Cartridge pages start at 128K words into external memory
  localparam int CART_BASE_W = XADDR_W - CART_PAGE_W - 12;

  logic [CART_PAGE_W-1:0] cart_page;
  xaddr_t                 x_cart_addr;
  xaddr_t                 x_cpu_addr;

  always_ff @(posedge clk) begin
    if (cpu_reset)
      cart_page <= '0;
    else if (cart_wr_rq_i)
      cart_page <= cpu_addr_i[CART_PAGE_W:1];  // Page comes from the address bus
  end

  //----------------------------------------
  // Address mapping
  //----------------------------------------
  assign x_cart_addr = {CART_BASE_W'(1), cart_page, cpu_addr_i[12:1]};
  assign x_cpu_addr  = {{(XADDR_W - CPU_AW + 1){1'b0}}, cpu_addr_i[CPU_AW-1:1]};  // Word address

  assign xaddr_o = cart_sel_i ? x_cart_addr : x_cpu_addr;

endmodule

//--- logic/cpu_bus_decode.sv
/*
 * CPU address decode, rising-edge request strobes and CPU ready.
 * ROM and cartridge windows are write protected; ready holds until the cycle ends.
 */
`timescale 1ns/10ps

module cpu_bus_decode (
  input  logic                   clk,
  input  logic                   cpu_reset,
  input  ti_glue_pkg::cpu_addr_t cpu_addr_i,
  input  logic                   cpu_rd_i,
  input  logic                   cpu_wr_i,
  input  logic                   mem_ack_i,
  input  logic                   vdp_ack_i,
  output logic                   xram_sel_o,
  output logic                   cart_sel_o,
  output logic                   vdp_rd_o,
  output logic                   vdp_wr_o,
  output logic                   mem_rd_rq_o,
  output logic                   mem_wr_rq_o,
  output logic                   cart_wr_rq_o,
  output logic                   ready_o
);

  logic last_rd, last_wr;  // Previous cycle copies for edge detect
  logic rd_edge, wr_edge;
  logic vdp_sel;           // VDP port access in progress
  logic ready_now;
  logic keep_ready;

  //----------------------------------------
  // Chip selects
  //----------------------------------------
  assign cart_sel_o = (cpu_addr_i[15:13] == 3'b011);  // 6000-7FFF

  assign xram_sel_o = ((cpu_addr_i[15:13] == 3'b000) && !cpu_wr_i)  // ROM, read only
                    || (cpu_addr_i[15:13] == 3'b001)                 // 2000-3FFF low 8K
                    || (cart_sel_o && !cpu_wr_i)                     // Cartridge, read only
                    || (cpu_addr_i[15:10] == 6'b100000)              // 8000-83FF scratchpad
                    || (cpu_addr_i[15:13] == 3'b101)                 // A000-BFFF
                    || (cpu_addr_i[15:14] == 2'b11);                 // C000-FFFF

  assign vdp_sel  = (cpu_rd_i && cpu_addr_i[15:8] == 8'h88)
                 || (cpu_wr_i && cpu_addr_i[15:8] == 8'h8c);
  assign vdp_rd_o = cpu_rd_i && (cpu_addr_i[15:8] == 8'h88);

  // First cycle of rd or wr
  assign rd_edge = cpu_rd_i && !last_rd;
  assign wr_edge = cpu_wr_i && !last_wr;

  assign vdp_wr_o     = wr_edge && (cpu_addr_i[15:8] == 8'h8c);
  assign mem_rd_rq_o  = rd_edge && xram_sel_o;
  assign mem_wr_rq_o  = wr_edge && xram_sel_o;
  assign cart_wr_rq_o = wr_edge && cart_sel_o;  // Bank switch, even though not selected

  //----------------------------------------
  // Ready
  //----------------------------------------
  assign ready_now = (xram_sel_o && mem_ack_i) || (vdp_sel && vdp_ack_i);
  assign ready_o   = ready_now || keep_ready;

  always_ff @(posedge clk) begin
    if (cpu_reset) begin
      last_rd    <= 1'b0;
      last_wr    <= 1'b0;
      keep_ready <= 1'b0;
    end else begin
      last_rd <= cpu_rd_i;
      last_wr <= cpu_wr_i;
      if (!cpu_rd_i && !cpu_wr_i)
        keep_ready <= 1'b0;  // Cycle over
      else if (ready_now)
        keep_ready <= 1'b1;  // Remember the ack
    end
  end

  // The CPU never reads and writes in the same cycle
  a_rd_wr_excl: assert property (@(posedge clk) disable iff (cpu_reset)
    !(cpu_rd_i && cpu_wr_i))
    else $error("cpu_rd_i and cpu_wr_i both high");

endmodule

//--- logic/ti_glue_pkg.sv
/*
 * Shared constants and types for the TI-99/4A system glue.
 * Modules use scoped names in their port lists and a wildcard import inside the body.
 */
package ti_glue_pkg;

  // Widths fixed by the machine
  localparam int CPU_AW       = 16;  // CPU byte address
  localparam int CPU_DW       = 16;  // CPU data bus
  localparam int XADDR_W      = 23;  // External memory word address
  localparam int CART_PAGE_W  = 5;   // Extended Basic bank number
  localparam int KEY_ROWS     = 8;   // Keyboard matrix rows
  localparam int LOADER_OFS_W = 12;  // Loader register offset
  localparam int TRACE_AW     = 8;   // 256 trace entries

  typedef logic [CPU_AW-1:0]  cpu_addr_t;
  typedef logic [XADDR_W-1:0] xaddr_t;

  // One recorded bus cycle, 36 bits
  typedef struct packed {
    logic [3:0]        ctrl;  // iaq, int_req, wr, rd
    logic [CPU_DW-1:0] data;  // dout on writes, din on reads
    cpu_addr_t         addr;
  } trace_entry_t;

  //----------------------------------------
  // Loader offset, two decodings
  //----------------------------------------
  typedef struct packed {
    logic                    is_trace;  // Low for registers
    logic [LOADER_OFS_W-6:0] pad_zero;  // Must be zero for a register hit
    logic [3:0]              reg_idx;   // 0-7 keyboard rows, 8-9 control
  } loader_reg_view_t;

  typedef struct packed {
    logic                           is_trace;  // High for trace entries
    logic [TRACE_AW-1:0]            entry;     // Trace buffer index
    logic [LOADER_OFS_W-TRACE_AW-2:0] byte_sel;  // Byte within the 8-byte entry
  } loader_trace_view_t;

  typedef union packed {
    loader_reg_view_t   reg_view;
    loader_trace_view_t trace_view;
  } loader_ofs_u;

endpackage
